// File: verilog/tl_consts.svh
`ifndef TL_CONSTS_SVH
`define TL_CONSTS_SVH

// Data path width and bytes per D beat
`define TL_XLEN 32
`define TL_BEAT_BYTES 4

// Largest log2 byte count that the PMA map accepts
`define TL_MAX_SIZE 4

// Backing RAM
`define TL_MEM_WORDS 256
`define TL_DTIM_BASE 32'h8000_0000

`endif

// File: verilog/tl_pkg.sv
package tl_pkg;

	// A channel opcodes, UL subset plus the UH ones we refuse
	typedef enum logic [2:0] {
		put_full = 3'd0,
		put_partial = 3'd1,
		arithmetic = 3'd2,
		logical = 3'd3,
		get = 3'd4,
		intent = 3'd5
	} tl_a_opcode_e;

	// D channel opcodes
	typedef enum logic [2:0] {
		access_ack = 3'd0,
		access_ack_data = 3'd1,
		hint_ack = 3'd2
	} tl_d_opcode_e;

	// Log2 of the byte count
	typedef logic [3:0] tl_size_t;

	// Request tag, echoed back on D
	typedef logic [1:0] tl_source_t;

endpackage

// File: verilog/pma_pkg.sv
package pma_pkg;

	// a atomics, r read, w write, x execute, c cacheable
	typedef struct packed {
		logic a;
		logic r;
		logic w;
		logic x;
		logic c;
	} pma_flags_t;

	// Same word seen as raw mode bits or as named flags
	typedef union packed {
		logic [4:0] modes;
		pma_flags_t flags;
	} pma_attr_u;

	typedef enum logic [2:0] {
		none,
		debug,
		error_dev,
		rom,
		clint,
		plic,
		mmio,
		dtim
	} pma_region_e;

endpackage

// File: verilog/pma_map.sv
`timescale 1ns/1ps
`include "tl_consts.svh"

module pma_map import tl_pkg::*, pma_pkg::*; (
	input  logic [`TL_XLEN-1:0] address,
	input  tl_size_t            size,
	output pma_attr_u           attr,
	output pma_region_e         region
);
	logic [`TL_XLEN-1:0] address_last;
	logic [`TL_XLEN-1:0] size_mask;
	pma_region_e region_last;

	function automatic pma_region_e region_of(input logic [`TL_XLEN-1:0] addr);
		region_of = none;
		if (addr < 32'h0000_1000)
			region_of = debug;
		else if (addr >= 32'h0000_3000 && addr < 32'h0000_4000)
			region_of = error_dev;
		else if (addr >= 32'h0001_0000 && addr < 32'h0002_0000)
			region_of = rom;
		else if (addr >= 32'h0200_0000 && addr < 32'h0201_0000)
			region_of = clint;
		else if (addr >= 32'h0c00_0000 && addr < 32'h1000_0000)
			region_of = plic;
		else if (addr >= 32'h6000_0000 && addr < `TL_DTIM_BASE)
			region_of = mmio;
		else if (addr >= `TL_DTIM_BASE && addr < `TL_DTIM_BASE + 32'h4000)
			region_of = dtim;
	endfunction

	// Raw a r w x c bits per region
	function automatic logic [4:0] modes_of(input pma_region_e r);
		case (r)
			debug, error_dev, dtim: modes_of = 5'b11110;
			rom: modes_of = 5'b01010;
			clint, plic: modes_of = 5'b11100;
			mmio: modes_of = 5'b01110;
			default: modes_of = 5'b00000;
		endcase
	endfunction

	assign size_mask = (32'd1 << size) - 32'd1;
	assign address_last = address + size_mask;
	assign region = region_of(address);
	assign region_last = region_of(address_last);

	always_comb begin
		attr.modes = modes_of(region) & modes_of(region_last);
		if (size > `TL_MAX_SIZE)
			attr.modes = 5'b00000;
		// Misaligned access keeps only execute
		if (|(address & size_mask)) begin
			attr.flags.a = 1'b0;
			attr.flags.r = 1'b0;
			attr.flags.w = 1'b0;
			attr.flags.c = 1'b0;
		end
	end
endmodule

// File: verilog/beat_counter.sv
`timescale 1ns/1ps

module beat_counter import tl_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       start,
	input  tl_size_t   size,
	input  logic       advance,
	output logic [1:0] beat,
	output logic       last
);
	logic [1:0] final_beat;

	// Idle state is a single beat, so puts need no start
	assign last = beat == final_beat;

	always_ff @(posedge clock) begin
		if (reset) begin
			beat <= 2'd0;
			final_beat <= 2'd0;
		end else if (start) begin
			beat <= 2'd0;
			if (size <= 4'd2)
				final_beat <= 2'd0;
			else if (size == 4'd3)
				final_beat <= 2'd1;
			else
				final_beat <= 2'd3;
		end else if (advance) begin
			if (last) begin
				beat <= 2'd0;
				final_beat <= 2'd0;
			end else begin
				beat <= beat + 2'd1;
			end
		end
	end
endmodule

// File: verilog/tl_slave_fsm.sv
`timescale 1ns/1ps
`include "tl_consts.svh"

module tl_slave_fsm import tl_pkg::*, pma_pkg::*; (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      a_valid,
	output logic                      a_ready,
	input  tl_a_opcode_e              a_opcode,
	input  logic [2:0]                a_param,
	input  tl_size_t                  a_size,
	input  tl_source_t                a_source,
	input  logic [`TL_XLEN-1:0]       a_address,
	input  logic [`TL_BEAT_BYTES-1:0] a_mask,
	input  logic [`TL_XLEN-1:0]       a_data,
	output logic                      d_valid,
	input  logic                      d_ready,
	output tl_d_opcode_e              d_opcode,
	output tl_size_t                  d_size,
	output tl_source_t                d_source,
	output logic [`TL_XLEN-1:0]       d_data,
	output logic                      d_error,
	input  pma_attr_u                 attr,
	input  logic                      last,
	input  logic [1:0]                beat,
	input  logic [`TL_XLEN-1:0]       rdata,
	output logic                      start,
	output logic                      advance,
	output logic [`TL_XLEN-1:0]       op_address,
	output tl_size_t                  op_size,
	output logic                      mem_write,
	output logic [`TL_XLEN-1:0]       mem_address,
	output logic [`TL_BEAT_BYTES-1:0] mem_mask,
	output logic [`TL_XLEN-1:0]       mem_wdata
);
	typedef enum logic {idle, respond} state_e;

	state_e state;
	logic out_of_reset;
	logic accept;
	logic is_get;
	logic is_put;
	logic get_ok;
	logic put_ok;
	logic read_ok;
	logic [`TL_XLEN-1:0] lat_address;
	tl_size_t lat_size;
	logic [1:0] next_beat;

	assign advance = d_valid && d_ready;
	assign a_ready = out_of_reset && (state == idle || (advance && last));
	assign accept = a_valid && a_ready;
	assign d_valid = state == respond;

	// While a request can be taken the map sees the incoming one
	assign op_address = a_ready ? a_address : lat_address;
	assign op_size = a_ready ? a_size : lat_size;

	// UL requires param zero on Get and Put
	assign is_get = a_opcode == get && a_param == 3'd0;
	assign is_put = (a_opcode == put_full || a_opcode == put_partial) && a_param == 3'd0;
	assign get_ok = attr.flags.r;
	assign put_ok = attr.flags.w && a_size <= 4'd2;
	assign start = accept && is_get;

	// D data is registered, so the RAM is read one beat ahead
	assign next_beat = beat + 2'd1;
	assign mem_address = a_ready ? a_address : lat_address + {28'd0, next_beat, 2'b00};
	assign mem_write = accept && is_put && put_ok;
	assign mem_mask = a_mask;
	assign mem_wdata = a_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
			out_of_reset <= 1'b0;
		end else begin
			out_of_reset <= 1'b1;
			if (accept)
				state <= respond;
			else if (advance && last)
				state <= idle;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			lat_address <= a_address;
			lat_size <= a_size;
			d_size <= a_size;
			d_source <= a_source;
			read_ok <= is_get && get_ok;
			if (is_get) begin
				d_opcode <= access_ack_data;
				d_error <= !get_ok;
				d_data <= get_ok ? rdata : '0;
			end else begin
				// Puts, refused opcodes and bad params get one AccessAck
				d_opcode <= access_ack;
				d_error <= !(is_put && put_ok);
				d_data <= '0;
			end
		end else if (advance && !last) begin
			d_data <= read_ok ? rdata : '0;
		end
	end
endmodule

// File: verilog/slave_mem.sv
`timescale 1ns/1ps
`include "tl_consts.svh"

module slave_mem import pma_pkg::*; (
	input  logic                      clock,
	input  logic                      write,
	input  logic [`TL_XLEN-1:0]       address,
	input  logic [`TL_BEAT_BYTES-1:0] mask,
	input  logic [`TL_XLEN-1:0]       wdata,
	input  pma_region_e               region,
	output logic [`TL_XLEN-1:0]       rdata
);
	localparam int index_bits = $clog2(`TL_MEM_WORDS);

	logic [`TL_XLEN-1:0] ram [`TL_MEM_WORDS];
	logic [index_bits-1:0] index;
	logic in_dtim;

	// Word index, the RAM aliases across the dtim window
	assign index = address[index_bits+1:2];
	assign in_dtim = region == dtim;

	always_ff @(posedge clock) begin
		if (write && in_dtim) begin
			for (int i = 0; i < `TL_BEAT_BYTES; i++) begin
				if (mask[i])
					ram[index][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

	// Other readable regions are not backed
	assign rdata = in_dtim ? ram[index] : '0;
endmodule

// File: verilog/tl_mem_slave_top.sv
`timescale 1ns/1ps
`include "tl_consts.svh"

module tl_mem_slave_top import tl_pkg::*, pma_pkg::*; (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      a_valid,
	output logic                      a_ready,
	input  tl_a_opcode_e              a_opcode,
	input  logic [2:0]                a_param,
	input  tl_size_t                  a_size,
	input  tl_source_t                a_source,
	input  logic [`TL_XLEN-1:0]       a_address,
	input  logic [`TL_BEAT_BYTES-1:0] a_mask,
	input  logic [`TL_XLEN-1:0]       a_data,
	output logic                      d_valid,
	input  logic                      d_ready,
	output tl_d_opcode_e              d_opcode,
	output tl_size_t                  d_size,
	output tl_source_t                d_source,
	output logic [`TL_XLEN-1:0]       d_data,
	output logic                      d_error
);
	pma_attr_u attr;
	pma_region_e region;
	logic [`TL_XLEN-1:0] op_address;
	tl_size_t op_size;
	logic start;
	logic advance;
	logic [1:0] beat;
	logic last;
	logic mem_write;
	logic [`TL_XLEN-1:0] mem_address;
	logic [`TL_BEAT_BYTES-1:0] mem_mask;
	logic [`TL_XLEN-1:0] mem_wdata;
	logic [`TL_XLEN-1:0] rdata;

	pma_map pma_map_i (
		.address (op_address),
		.size    (op_size   ),
		.attr    (attr      ),
		.region  (region    )
	);

	beat_counter beat_counter_i (
		.clock   (clock  ),
		.reset   (reset  ),
		.start   (start  ),
		.size    (op_size),
		.advance (advance),
		.beat    (beat   ),
		.last    (last   )
	);

	tl_slave_fsm tl_slave_fsm_i (
		.clock       (clock      ),
		.reset       (reset      ),
		.a_valid     (a_valid    ),
		.a_ready     (a_ready    ),
		.a_opcode    (a_opcode   ),
		.a_param     (a_param    ),
		.a_size      (a_size     ),
		.a_source    (a_source   ),
		.a_address   (a_address  ),
		.a_mask      (a_mask     ),
		.a_data      (a_data     ),
		.d_valid     (d_valid    ),
		.d_ready     (d_ready    ),
		.d_opcode    (d_opcode   ),
		.d_size      (d_size     ),
		.d_source    (d_source   ),
		.d_data      (d_data     ),
		.d_error     (d_error    ),
		.attr        (attr       ),
		.last        (last       ),
		.beat        (beat       ),
		.rdata       (rdata      ),
		.start       (start      ),
		.advance     (advance    ),
		.op_address  (op_address ),
		.op_size     (op_size    ),
		.mem_write   (mem_write  ),
		.mem_address (mem_address),
		.mem_mask    (mem_mask   ),
		.mem_wdata   (mem_wdata  )
	);

	slave_mem slave_mem_i (
		.clock   (clock      ),
		.write   (mem_write  ),
		.address (mem_address),
		.mask    (mem_mask   ),
		.wdata   (mem_wdata  ),
		.region  (region     ),
		.rdata   (rdata      )
	);
endmodule

// File: dv/tb_tl_mem_slave.sv
`timescale 1ns/1ps
`include "tl_consts.svh"

module tb_tl_mem_slave import tl_pkg::*; ();
	localparam int max_lines = 64;

	logic clock;
	logic reset;
	logic a_valid;
	logic a_ready;
	tl_a_opcode_e a_opcode;
	logic [2:0] a_param;
	tl_size_t a_size;
	tl_source_t a_source;
	logic [`TL_XLEN-1:0] a_address;
	logic [`TL_BEAT_BYTES-1:0] a_mask;
	logic [`TL_XLEN-1:0] a_data;
	logic d_valid;
	logic d_ready;
	tl_d_opcode_e d_opcode;
	tl_size_t d_size;
	tl_source_t d_source;
	logic [`TL_XLEN-1:0] d_data;
	logic d_error;

	// One entry per golden line
	logic [2:0] g_opcode [max_lines];
	tl_size_t g_size [max_lines];
	tl_source_t g_source [max_lines];
	logic [`TL_XLEN-1:0] g_address [max_lines];
	logic [`TL_BEAT_BYTES-1:0] g_mask [max_lines];
	logic [`TL_XLEN-1:0] g_data [max_lines];
	logic [2:0] g_d_opcode [max_lines];
	logic g_error [max_lines];
	int g_beats [max_lines];
	logic [`TL_XLEN-1:0] g_words [max_lines][4];

	int line_count;
	int accepted_count;
	int error_count;
	int passed_count;
	int failed_count;
	int cycle_count;
	int cycle_limit;
	logic [31:0] lfsr;

	tl_mem_slave_top tl_mem_slave_top_i (.*);

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		lfsr_next = state >> 1;
		if (state[0])
			lfsr_next = lfsr_next ^ 32'h8020_0003;
	endfunction

	function automatic logic take_bit();
		lfsr = lfsr_next(lfsr);
		return lfsr[0];
	endfunction

	task automatic check_opcode(input string name, input tl_d_opcode_e expected,
			input tl_d_opcode_e actual);
		if (actual !== expected) begin
			error_count++;
			$display("error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic check_data(input string name, input logic [`TL_XLEN-1:0] expected,
			input logic [`TL_XLEN-1:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("error at %0t: %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			error_count++;
			$display("error at %0t: %s expected %b got %b", $time, name, expected, actual);
		end
	endtask

	task automatic check_source(input string name, input tl_source_t expected,
			input tl_source_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic check_size(input string name, input tl_size_t expected,
			input tl_size_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic load_golden();
		int fd;
		int fields;
		string text;
		line_count = 0;
		fd = $fopen("dv/tl_mem_slave_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open dv/tl_mem_slave_golden.txt");
		end else begin
			while ($fgets(text, fd) > 0) begin
				if (text.len() > 0 && text[0] != "#" && line_count < max_lines) begin
					fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
						g_opcode[line_count], g_size[line_count], g_source[line_count],
						g_address[line_count], g_mask[line_count], g_data[line_count],
						g_d_opcode[line_count], g_error[line_count], g_beats[line_count],
						g_words[line_count][0], g_words[line_count][1],
						g_words[line_count][2], g_words[line_count][3]);
					if (fields == 13) begin
						line_count++;
					end else if (fields > 0) begin
						error_count++;
						$display("golden line has %0d of 13 columns and was skipped", fields);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Requests go out in file order, with random idle gaps
	task automatic send_requests();
		for (int i = 0; i < line_count; i++) begin
			while (take_bit() && take_bit()) begin
				@(posedge clock);
				#1;
			end
			a_valid = 1'b1;
			a_opcode = tl_a_opcode_e'(g_opcode[i]);
			a_size = g_size[i];
			a_source = g_source[i];
			a_address = g_address[i];
			a_mask = g_mask[i];
			a_data = g_data[i];
			@(negedge clock);
			while (!a_ready)
				@(negedge clock);
			@(posedge clock);
			#1;
			accepted_count++;
			a_valid = 1'b0;
		end
	endtask

	// Sampled at the falling edge, the beat transfers on the next rising one
	task automatic collect_responses();
		int errors_before;
		logic beat_seen;
		for (int i = 0; i < line_count; i++) begin
			errors_before = error_count;
			for (int b = 0; b < g_beats[i]; b++) begin
				beat_seen = 1'b0;
				while (!beat_seen) begin
					@(negedge clock);
					if (d_valid && accepted_count <= i) begin
						error_count++;
						$display("d_valid is high at %0t with no request outstanding", $time);
					end
					beat_seen = d_valid && d_ready;
				end
				check_opcode("d_opcode", tl_d_opcode_e'(g_d_opcode[i]), d_opcode);
				check_flag("d_error", g_error[i], d_error);
				check_source("d_source", g_source[i], d_source);
				check_size("d_size", g_size[i], d_size);
				if (g_d_opcode[i] == 3'd1)
					check_data("d_data", g_words[i][b], d_data);
				// Next request may be taken only on the last beat
				check_flag("a_ready", b == g_beats[i] - 1, a_ready);
			end
			if (error_count == errors_before) begin
				passed_count++;
				$display("request %0d at %h: %0d beats ok", i, g_address[i], g_beats[i]);
			end else begin
				failed_count++;
				$display("request %0d at %h: mismatch", i, g_address[i]);
			end
		end
	endtask

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// D ready drops about one cycle in four
	initial begin
		@(negedge reset);
		forever begin
			@(posedge clock);
			#1;
			d_ready = !(take_bit() && take_bit());
		end
	end

	initial begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Timed out after %0d cycles with %0d of %0d requests accepted",
			cycle_count, accepted_count, line_count);
		$display("Regression failed");
		$finish;
	end

	initial begin
		reset = 1'b1;
		a_valid = 1'b0;
		a_opcode = get;
		a_param = 3'd0;
		a_size = '0;
		a_source = '0;
		a_address = '0;
		a_mask = '0;
		a_data = '0;
		d_ready = 1'b0;
		lfsr = 32'h5366;
		load_golden();
		if (line_count == 0) begin
			$display("no usable request lines in the golden file");
			$display("Regression failed");
			$finish;
		end else begin
			cycle_limit = 40 * line_count;
			repeat (2) @(posedge clock);
			#1;
			reset = 1'b0;
			@(negedge clock);
			check_flag("a_ready", 1'b0, a_ready);
			check_flag("d_valid", 1'b0, d_valid);
			@(negedge clock);
			check_flag("a_ready", 1'b1, a_ready);
			check_flag("d_valid", 1'b0, d_valid);
			@(posedge clock);
			#1;
			fork
				send_requests();
				collect_responses();
			join
			$display("%0d requests, %0d passed, %0d failed, %0d errors",
				line_count, passed_count, failed_count, error_count);
			if (error_count == 0) begin
				$display("Regression passed");
			end else begin
				$display("Regression failed");
			end
			$finish;
		end
	end
endmodule

// File: all.f
+incdir+verilog
verilog/tl_pkg.sv
verilog/pma_pkg.sv
verilog/pma_map.sv
verilog/beat_counter.sv
verilog/tl_slave_fsm.sv
verilog/slave_mem.sv
verilog/tl_mem_slave_top.sv
dv/tb_tl_mem_slave.sv

// File: Bender.yml
package:
  name: tl_mem_slave

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/tl_pkg.sv
      - verilog/pma_pkg.sv
      - verilog/pma_map.sv
      - verilog/beat_counter.sv
      - verilog/tl_slave_fsm.sv
      - verilog/slave_mem.sv
      - verilog/tl_mem_slave_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/tb_tl_mem_slave.sv

// File: dv/tl_mem_slave_golden.txt
# a_opcode a_size a_source a_address a_mask a_data, then expected d_opcode d_error beats
# and four D data words (only compared for AccessAckData), all hex
0 2 1 80000000 f 11223344 0 0 1 0 0 0 0
4 2 2 80000000 0 0 1 0 1 11223344 0 0 0
1 2 3 80000000 5 aabbccdd 0 0 1 0 0 0 0
4 2 0 80000000 0 0 1 0 1 11bb33dd 0 0 0
1 0 1 80000001 2 00005a00 0 0 1 0 0 0 0
1 1 2 80000002 c 77660000 0 0 1 0 0 0 0
4 2 3 80000000 0 0 1 0 1 77665add 0 0 0
0 2 0 80000010 f a0a1a2a3 0 0 1 0 0 0 0
0 2 1 80000014 f b0b1b2b3 0 0 1 0 0 0 0
0 2 2 80000018 f c0c1c2c3 0 0 1 0 0 0 0
0 2 3 8000001c f d0d1d2d3 0 0 1 0 0 0 0
4 4 1 80000010 0 0 1 0 4 a0a1a2a3 b0b1b2b3 c0c1c2c3 d0d1d2d3
4 3 2 80000018 0 0 1 0 2 c0c1c2c3 d0d1d2d3 0 0
4 4 3 80000010 0 0 1 0 4 a0a1a2a3 b0b1b2b3 c0c1c2c3 d0d1d2d3
0 2 0 00010000 f deadbeef 0 1 1 0 0 0 0
4 2 1 00005000 0 0 1 1 1 0 0 0 0
4 4 2 20000000 0 0 1 1 4 0 0 0 0
4 2 3 80000002 0 0 1 1 1 0 0 0 0
4 3 0 80000004 0 0 1 1 2 0 0 0 0
2 2 1 80000000 f 00000001 0 1 1 0 0 0 0
3 2 2 80000000 f 00000001 0 1 1 0 0 0 0
5 2 3 80000000 0 0 0 1 1 0 0 0 0
0 3 0 80000008 f 12345678 0 1 1 0 0 0 0
4 2 1 80000000 0 0 1 0 1 77665add 0 0 0
4 2 2 00000100 0 0 1 0 1 0 0 0 0
4 4 3 00000000 0 0 1 0 4 0 0 0 0
0 2 0 60000000 f cafef00d 0 0 1 0 0 0 0
4 2 1 60000000 0 0 1 0 1 0 0 0 0
4 2 2 80000014 0 0 1 0 1 b0b1b2b3 0 0 0
